// ==== src/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN     = 32;
    localparam int PARCEL_W = 16;

    // pc increments for a compressed and a full-width instruction
    localparam logic [XLEN-1:0] ILEN_STEP_C = 32'd2;
    localparam logic [XLEN-1:0] ILEN_STEP_W = 32'd4;

    // major opcodes produced by the expander
    localparam logic [6:0] OPC_ADDI   = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [XLEN-1:0] EBREAK_WORD = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};

    // quadrant field, parcel[1:0]; 11 marks a full 32-bit instruction
    localparam logic [1:0] C_Q0   = 2'b00;
    localparam logic [1:0] C_Q1   = 2'b01;
    localparam logic [1:0] C_Q2   = 2'b10;
    localparam logic [1:0] C_FULL = 2'b11;

    // funct3 field, parcel[15:13], per quadrant
    localparam logic [2:0] C0_LW   = 3'b010;
    localparam logic [2:0] C0_SW   = 3'b110;
    localparam logic [2:0] C1_ADDI = 3'b000;
    localparam logic [2:0] C1_JAL  = 3'b001;
    localparam logic [2:0] C1_LI   = 3'b010;
    localparam logic [2:0] C1_LUI  = 3'b011;
    localparam logic [2:0] C1_J    = 3'b101;
    localparam logic [2:0] C1_BEQZ = 3'b110;
    localparam logic [2:0] C1_BNEZ = 3'b111;
    localparam logic [2:0] C2_MISC = 3'b100; // jr, mv, ebreak, jalr, add

    localparam logic [2:0] F3_WORD = 3'b010; // lw / sw width
    localparam logic [2:0] F3_ADD  = 3'b000;

    localparam logic [4:0] REG_X0 = 5'd0;
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_SP = 5'd2;

    // rd', rs1', rs2' select x8..x15
    localparam logic [1:0] REG_PRIME_BASE = 2'b01;

    typedef struct packed {
        logic [PARCEL_W-1:0] hi;
        logic [PARCEL_W-1:0] lo;
    } parcel_pair_t;

    // one memory word, seen as a whole instruction or as two halfword parcels
    typedef union packed {
        logic [XLEN-1:0] instr;
        parcel_pair_t    parcel;
    } fetch_word_u;

endpackage

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    localparam logic [isa_pkg::XLEN-1:0] RESET_PC = 32'h4000_0000;

    // controller states
    localparam logic [1:0] ST_FETCH    = 2'd0; // stb raised, address from pc
    localparam logic [1:0] ST_WAIT_ACK = 2'd1;
    localparam logic [1:0] ST_DRAIN    = 2'd2; // cycle overtaken by a redirect
    localparam logic [1:0] ST_ISSUE    = 2'd3;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic [isa_pkg::XLEN-1:0] adr; // byte address, always word aligned
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        isa_pkg::fetch_word_u dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] instr;   // expanded when is_c is set
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] pc_next;
        logic                     is_c;
        logic                     illegal;
    } fetch_out_t;

    typedef struct packed {
        logic have_instr; // a whole instruction is available
        logic need_word;  // aligner waits for a memory word
        logic is_c;
    } align_stat_t;

endpackage

// ==== src/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  fetch_pkg::align_stat_t        stat_i,
    input  logic [isa_pkg::XLEN-1:0]      pc_i,
    output fetch_pkg::wb_req_t            wb_req_o,
    input  logic                          ack_i,
    output logic                          load_o,
    output logic                          next_word_o,
    output logic                          issue_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    input  logic                          redirect_i
);

    logic [1:0]               state_q;
    logic [1:0]               state_d;
    logic                     next_word_q; // fetch the word after pc (spill case)
    logic                     flushed_q;   // aligner emptied, nothing loaded since
    logic [isa_pkg::XLEN-1:0] adr_q;
    logic [isa_pkg::XLEN-1:0] fetch_adr;
    logic                     bus_live;

    assign fetch_adr = {pc_i[isa_pkg::XLEN-1:2], 2'b00}
                     + (next_word_q ? isa_pkg::ILEN_STEP_W : '0);

    assign bus_live = (state_q != fetch_pkg::ST_ISSUE);

    assign wb_req_o.cyc = bus_live;
    assign wb_req_o.stb = bus_live;
    assign wb_req_o.adr = (state_q == fetch_pkg::ST_FETCH) ? fetch_adr : adr_q;

    // data of a drained cycle never reaches the aligner
    assign load_o = ack_i && !redirect_i
                 && (state_q == fetch_pkg::ST_FETCH || state_q == fetch_pkg::ST_WAIT_ACK);

    assign out_valid_o = (state_q == fetch_pkg::ST_ISSUE) && stat_i.have_instr;
    assign issue_o     = out_valid_o && out_ready_i && !redirect_i;
    assign next_word_o = next_word_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::ST_FETCH, fetch_pkg::ST_WAIT_ACK: begin
                if (redirect_i) begin
                    state_d = ack_i ? fetch_pkg::ST_ISSUE : fetch_pkg::ST_DRAIN;
                end else if (ack_i) begin
                    state_d = fetch_pkg::ST_ISSUE;
                end else begin
                    state_d = fetch_pkg::ST_WAIT_ACK;
                end
            end
            fetch_pkg::ST_DRAIN: begin
                if (ack_i) state_d = fetch_pkg::ST_ISSUE; // one idle cycle before refetch
            end
            default: begin
                if (redirect_i || stat_i.need_word) state_d = fetch_pkg::ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= fetch_pkg::ST_ISSUE; // aligner is empty, so FETCH follows
            next_word_q <= 1'b0;
            flushed_q   <= 1'b1;
        end else begin
            state_q <= state_d;
            if (redirect_i) begin
                next_word_q <= 1'b0;
                flushed_q   <= 1'b1;
            end else begin
                if (load_o) flushed_q <= 1'b0;
                // a full instruction in the upper half waits for the next word
                if (state_q == fetch_pkg::ST_ISSUE && stat_i.need_word) begin
                    next_word_q <= pc_i[1] && !flushed_q;
                end
            end
        end
    end

    // hold the address for the rest of the bus cycle
    always_ff @(posedge clk_i) begin
        if (state_q == fetch_pkg::ST_FETCH) adr_q <= fetch_adr;
    end

endmodule

// ==== src/pc_counter.sv ====
module pc_counter (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     issue_i,
    input  logic                     is_c_i,
    input  logic                     redirect_i,
    input  logic [isa_pkg::XLEN-1:0] redirect_pc_i,
    output logic [isa_pkg::XLEN-1:0] pc_o,
    output logic [isa_pkg::XLEN-1:0] pc_next_o
);

    logic [isa_pkg::XLEN-1:0] pc_q;

    assign pc_o      = pc_q;
    assign pc_next_o = pc_q + (is_c_i ? isa_pkg::ILEN_STEP_C : isa_pkg::ILEN_STEP_W);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= {redirect_pc_i[isa_pkg::XLEN-1:1], 1'b0}; // halfword aligned target
        end else if (issue_i) begin
            pc_q <= pc_next_o;
        end
    end

endmodule

// ==== src/parcel_aligner.sv ====
module parcel_aligner (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     load_i,
    input  logic                     flush_i,
    input  isa_pkg::fetch_word_u     word_i,
    input  logic                     pc_half_i,
    input  logic                     issue_i,
    output fetch_pkg::align_stat_t   stat_o,
    output logic [isa_pkg::XLEN-1:0] raw_o
);

    isa_pkg::fetch_word_u             word_q;
    logic [isa_pkg::PARCEL_W-1:0]     spill_q;  // upper parcel of the previous word
    logic                             word_vld_q;
    logic                             spill_vld_q;
    logic [isa_pkg::PARCEL_W-1:0]     cur_parcel;
    logic                             cur_c;
    logic                             straddle_wait;

    // with a spill held, the instruction starts in the spill register
    always_comb begin
        if (!pc_half_i) begin
            cur_parcel = word_q.parcel.lo;
        end else if (spill_vld_q) begin
            cur_parcel = spill_q;
        end else begin
            cur_parcel = word_q.parcel.hi;
        end
    end

    assign cur_c         = (cur_parcel[1:0] != isa_pkg::C_FULL);
    assign straddle_wait = word_vld_q && pc_half_i && !spill_vld_q && !cur_c;

    assign stat_o.have_instr = word_vld_q && !straddle_wait;
    assign stat_o.need_word  = !word_vld_q || straddle_wait;
    assign stat_o.is_c       = cur_c;

    always_comb begin
        case ({pc_half_i, cur_c})
            2'b01:   raw_o = {{isa_pkg::PARCEL_W{1'b0}}, word_q.parcel.lo}; // aligned compressed
            2'b11:   raw_o = {{isa_pkg::PARCEL_W{1'b0}}, word_q.parcel.hi}; // upper compressed
            2'b10:   raw_o = {word_q.parcel.lo, spill_q};                   // straddling full
            default: raw_o = word_q.instr;                                  // aligned full
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            word_vld_q  <= 1'b0;
            spill_vld_q <= 1'b0;
        end else if (load_i) begin
            word_vld_q  <= 1'b1;
            spill_vld_q <= straddle_wait; // old upper half becomes the spill
        end else if (issue_i) begin
            spill_vld_q <= 1'b0;
            // the word is used up once pc steps past its upper half
            if (!spill_vld_q && (pc_half_i == cur_c)) word_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            word_q  <= word_i;
            spill_q <= word_q.parcel.hi;
        end
    end

endmodule

// ==== src/rvc_expander.sv ====
module rvc_expander (
    input  logic [isa_pkg::PARCEL_W-1:0] parcel_i,
    output logic [isa_pkg::XLEN-1:0]     instr_o,
    output logic                         illegal_o
);

    logic [1:0] quad;
    logic [2:0] funct3;
    logic [4:0] rd;      // full rd / rs1 field
    logic [4:0] rs2;     // full rs2 field
    logic [4:0] rd_p;    // prime register in [9:7]
    logic [4:0] rs2_p;   // prime register in [4:2]
    logic [4:0] jal_rd;

    assign quad   = parcel_i[1:0];
    assign funct3 = parcel_i[15:13];
    assign rd     = parcel_i[11:7];
    assign rs2    = parcel_i[6:2];
    assign rd_p   = {isa_pkg::REG_PRIME_BASE, parcel_i[9:7]};
    assign rs2_p  = {isa_pkg::REG_PRIME_BASE, parcel_i[4:2]};
    assign jal_rd = (funct3 == isa_pkg::C1_JAL) ? isa_pkg::REG_RA : isa_pkg::REG_X0;

    always_comb begin
        instr_o   = '0;
        illegal_o = 1'b0;
        case (quad)
            isa_pkg::C_Q0: begin
                case (funct3)
                    isa_pkg::C0_LW: instr_o = {5'b0, parcel_i[5], parcel_i[12:10], parcel_i[6],
                                               2'b00, rd_p, isa_pkg::F3_WORD, rs2_p,
                                               isa_pkg::OPC_LOAD};
                    isa_pkg::C0_SW: instr_o = {5'b0, parcel_i[5], parcel_i[12], rs2_p, rd_p,
                                               isa_pkg::F3_WORD, parcel_i[11:10], parcel_i[6],
                                               2'b00, isa_pkg::OPC_STORE};
                    default:        illegal_o = 1'b1;
                endcase
            end
            isa_pkg::C_Q1: begin
                case (funct3)
                    isa_pkg::C1_ADDI: instr_o = {{7{parcel_i[12]}}, parcel_i[6:2], rd,
                                                 isa_pkg::F3_ADD, rd, isa_pkg::OPC_ADDI};
                    isa_pkg::C1_LI:   instr_o = {{7{parcel_i[12]}}, parcel_i[6:2], isa_pkg::REG_X0,
                                                 isa_pkg::F3_ADD, rd, isa_pkg::OPC_ADDI};
                    isa_pkg::C1_LUI: begin
                        if (rd == isa_pkg::REG_SP) begin
                            illegal_o = 1'b1;   // c.addi16sp is outside the subset
                        end else begin
                            instr_o = {{15{parcel_i[12]}}, parcel_i[6:2], rd, isa_pkg::OPC_LUI};
                        end
                    end
                    isa_pkg::C1_J, isa_pkg::C1_JAL: begin
                        // offset scrambled into jal order imm[20|10:1|11|19:12]
                        instr_o = {parcel_i[12], parcel_i[8], parcel_i[10:9], parcel_i[6],
                                   parcel_i[7], parcel_i[2], parcel_i[11], parcel_i[5:3],
                                   {9{parcel_i[12]}}, jal_rd, isa_pkg::OPC_JAL};
                    end
                    isa_pkg::C1_BEQZ, isa_pkg::C1_BNEZ: begin
                        instr_o = {{4{parcel_i[12]}}, parcel_i[6:5], parcel_i[2], isa_pkg::REG_X0,
                                   rd_p, 2'b00, parcel_i[13], parcel_i[11:10], parcel_i[4:3],
                                   parcel_i[12], isa_pkg::OPC_BRANCH}; // bit 13 picks beq / bne
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            isa_pkg::C_Q2: begin
                if (funct3 != isa_pkg::C2_MISC) begin
                    illegal_o = 1'b1;
                end else if (rs2 != isa_pkg::REG_X0) begin
                    // mv adds to x0, add adds to rd
                    instr_o = {7'b0, rs2, parcel_i[12] ? rd : isa_pkg::REG_X0,
                               isa_pkg::F3_ADD, rd, isa_pkg::OPC_OP};
                end else if (parcel_i[12] && rd == isa_pkg::REG_X0) begin
                    instr_o = isa_pkg::EBREAK_WORD;
                end else begin
                    illegal_o = 1'b1;   // c.jr, c.jalr
                end
            end
            default: illegal_o = 1'b1;  // not a compressed parcel
        endcase
    end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    output fetch_pkg::wb_req_t       wb_req_o,
    input  fetch_pkg::wb_rsp_t       wb_rsp_i,
    output fetch_pkg::fetch_out_t    out_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    input  logic                     redirect_i,
    input  logic [isa_pkg::XLEN-1:0] redirect_pc_i
);

    fetch_pkg::align_stat_t   stat;
    logic                     load;
    logic                     issue;
    logic [isa_pkg::XLEN-1:0] pc;
    logic [isa_pkg::XLEN-1:0] pc_next;
    logic [isa_pkg::XLEN-1:0] raw;
    logic [isa_pkg::XLEN-1:0] exp_instr;
    logic                     exp_illegal;

    fetch_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stat_i      (stat),
        .pc_i        (pc),
        .wb_req_o    (wb_req_o),
        .ack_i       (wb_rsp_i.ack),
        .load_o      (load),
        .next_word_o (),          // spill fetch marker, observed by the bound checks
        .issue_o     (issue),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .redirect_i  (redirect_i)
    );

    pc_counter u_pc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_i       (issue),
        .is_c_i        (stat.is_c),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc),
        .pc_next_o     (pc_next)
    );

    parcel_aligner u_align (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_i    (load),
        .flush_i   (redirect_i),
        .word_i    (wb_rsp_i.dat),
        .pc_half_i (pc[1]),
        .issue_i   (issue),
        .stat_o    (stat),
        .raw_o     (raw)
    );

    rvc_expander u_rvc (
        .parcel_i  (raw[isa_pkg::PARCEL_W-1:0]),
        .instr_o   (exp_instr),
        .illegal_o (exp_illegal)
    );

    assign out_o.instr   = stat.is_c ? exp_instr : raw;
    assign out_o.pc      = pc;
    assign out_o.pc_next = pc_next;
    assign out_o.is_c    = stat.is_c;
    assign out_o.illegal = stat.is_c && exp_illegal; // full words pass unchecked

endmodule

// ==== sim/fetch_assertions.sv ====
module fetch_assertions (
    input logic                     clk_i,
    input logic                     rst_i,
    input fetch_pkg::wb_req_t       wb_req_o,
    input logic                     ack_i,
    input logic                     next_word_o,
    input logic                     out_valid_o,
    input logic                     out_ready_i,
    input logic                     redirect_i,
    input logic [isa_pkg::XLEN-1:0] pc_i
);

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_req_o.stb |-> wb_req_o.cyc)
        else $error("stb high without cyc");

    adr_held: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_req_o.stb && !ack_i |=> wb_req_o.stb && $stable(wb_req_o.adr))
        else $error("bus address or stb changed before ack");

    adr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_req_o.stb |-> wb_req_o.adr[1:0] == 2'b00)
        else $error("bus address not word aligned");

    // the word after pc is only wanted for a full instruction in the upper half
    spill_from_upper: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(wb_req_o.stb) && next_word_o |-> pc_i[1])
        else $error("spill fetch started with pc in the lower half");

    // pc is part of the output word to decode
    out_held: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i && !redirect_i |=> out_valid_o && $stable(pc_i))
        else $error("output dropped or changed under back-pressure");

endmodule

// ==== sim/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// reference expansion of one compressed parcel, result is {illegal, instr}
function automatic logic [32:0] expand_c(input logic [15:0] p);
    logic [11:0] imm_i;
    logic [11:0] off_w;
    logic [20:0] imm_j;
    logic [12:0] imm_b;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rsp;
    rd    = p[11:7];
    rs2   = p[6:2];
    rdp   = {2'b01, p[9:7]};
    rsp   = {2'b01, p[4:2]};
    imm_i = {{6{p[12]}}, p[12], p[6:2]};
    off_w = {5'b0, p[5], p[12:10], p[6], 2'b00};
    imm_j = {{9{p[12]}}, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
    imm_b = {{4{p[12]}}, p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};
    case ({p[1:0], p[15:13]})
        5'b00_010: return {1'b0, off_w, rdp, 3'b010, rsp, 7'b0000011};             // c.lw
        5'b00_110: return {1'b0, off_w[11:5], rsp, rdp, 3'b010, off_w[4:0], 7'b0100011};
        5'b01_000: return {1'b0, imm_i, rd, 3'b000, rd, 7'b0010011};               // c.addi
        5'b01_010: return {1'b0, imm_i, 5'd0, 3'b000, rd, 7'b0010011};             // c.li
        5'b01_011: begin
            if (rd == 5'd2) return {1'b1, 32'b0};                                 // addi16sp
            return {1'b0, {14{p[12]}}, p[12], p[6:2], rd, 7'b0110111};
        end
        5'b01_001, 5'b01_101: begin                                               // c.jal, c.j
            return {1'b0, imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12],
                    (p[15] ? 5'd0 : 5'd1), 7'b1101111};
        end
        5'b01_110, 5'b01_111: begin                                               // beqz / bnez
            return {1'b0, imm_b[12], imm_b[10:5], 5'd0, rdp, 2'b00, p[13],
                    imm_b[4:1], imm_b[11], 7'b1100011};
        end
        5'b10_100: begin
            if (rs2 != 5'd0) return {1'b0, 7'b0, rs2, (p[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
            if (p[12] && rd == 5'd0) return {1'b0, 32'h0010_0073};               // c.ebreak
            return {1'b1, 32'b0};
        end
        default: return {1'b1, 32'b0};
    endcase
endfunction

// random mix of full and compressed instructions packed as halfwords
task automatic build_program();
    int          hw;
    logic [31:0] w;
    logic [32:0] e;
    for (int i = 0; i < HW_N; i++) hmem[i] = 16'h3c00 ^ i[15:0];
    hw = 0;
    for (int i = 0; i < N_INSTR; i++) begin
        start_pc[i] = fetch_pkg::RESET_PC + 32'(2 * hw);
        w = $urandom;
        if ($urandom % 10 < 4) begin
            w[1:0]       = 2'b11;
            hmem[hw]     = w[15:0];
            hmem[hw + 1] = w[31:16];
            exp_instr[i] = w;
            exp_c[i]     = 1'b0;
            exp_ill[i]   = 1'b0;
            hw += 2;
        end else begin
            w[1:0]       = 2'($urandom % 3);
            hmem[hw]     = w[15:0];
            e            = expand_c(w[15:0]);
            exp_instr[i] = e[31:0];
            exp_ill[i]   = e[32];
            exp_c[i]     = 1'b1;
            hw += 1;
        end
    end
endtask

function automatic logic [31:0] mem_read(input logic [31:0] adr);
    int i;
    i = int'((adr - fetch_pkg::RESET_PC) >> 2);
    if (i >= 0 && i < HW_N / 2) return {hmem[2 * i + 1], hmem[2 * i]};
    return adr ^ 32'h6b1d_0000; // outside the program
endfunction

`endif

// ==== sim/fetch_tb.sv ====
module fetch_tb;

    localparam int N_INSTR   = 200;
    localparam int HW_N      = 2 * N_INSTR + 8;
    localparam int RST_CYC   = 10;
    localparam int MAX_REDIR = 16;
    localparam int MAX_LAT   = 24; // cycles per instruction, worst case
    localparam int TIMEOUT   = N_INSTR * (MAX_REDIR + 1) * MAX_LAT;

    logic                  clk_i;
    logic                  rst_i;
    fetch_pkg::wb_req_t    wb_req;
    fetch_pkg::wb_rsp_t    wb_rsp;
    fetch_pkg::fetch_out_t out;
    fetch_pkg::fetch_out_t prev_out;
    logic                  out_valid;
    logic                  out_ready_i;
    logic                  redirect_i;
    logic [31:0]           redirect_pc_i;

    logic [15:0] hmem [HW_N];
    logic [31:0] start_pc [N_INSTR];
    logic [31:0] exp_instr [N_INSTR];
    bit          exp_c [N_INSTR];
    bit          exp_ill [N_INSTR];

    int idx, err_cnt, chk_cnt, cycle_n, redir_cnt, redir_idx, wait_cnt;
    bit busy, first_chk, hold_chk, redir_seen;

    `include "fetch_model.svh"

    fetch_top dut0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wb_req_o      (wb_req),
        .wb_rsp_i      (wb_rsp),
        .out_o         (out),
        .out_valid_o   (out_valid),
        .out_ready_i   (out_ready_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i)
    );

    bind fetch_ctrl fetch_assertions chk0 (.*);

    always #20 clk_i = ~clk_i;

    // reset, memory responder, back-pressure and redirects
    always @(posedge clk_i) begin
        #1;
        cycle_n++;
        rst_i = (cycle_n < RST_CYC);
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (!rst_i && wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
                wb_rsp.ack       = 1'b1;
                wb_rsp.dat.instr = mem_read(wb_req.adr);
                busy             = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
        out_ready_i = ($urandom % 4 != 0);
        redirect_i  = 1'b0;
        if (first_chk && redir_cnt < MAX_REDIR && idx < N_INSTR - 20 && $urandom % 40 == 0) begin
            redir_idx     = $urandom % N_INSTR;
            redirect_i    = 1'b1;
            redirect_pc_i = start_pc[redir_idx];
            redir_cnt++;
        end
    end

    // run limit sized from the program length
    initial begin
        wait (cycle_n > TIMEOUT);
        $display("timeout: fetch did not finish the program within %0d cycles", TIMEOUT);
        $display("Some tests failed");
        $finish;
    end

    // checks at the falling edge, where every signal has settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            chk_cnt++;
            assert (!wb_req.cyc && !wb_req.stb && !out_valid) else begin
                err_cnt++;
                $display("ERR %0t: bus cycle or valid active during reset", $time);
            end
        end else begin
            if (!first_chk && wb_req.stb) begin
                first_chk = 1'b1;
                chk_cnt++;
                // stb is due in the first cycle after the last reset edge
                assert (wb_req.cyc && wb_req.adr == fetch_pkg::RESET_PC && !out_valid
                        && cycle_n == RST_CYC + 1)
                    else begin
                        err_cnt++;
                        $display("ERR %0t: first fetch at %h in cycle %0d, valid %0b", $time,
                                 wb_req.adr, cycle_n, out_valid);
                    end
            end
            if (hold_chk) begin
                chk_cnt++;
                assert (out_valid && out == prev_out) else begin
                    err_cnt++;
                    $display("ERR %0t: output changed while stalled", $time);
                end
            end
            if (redir_seen) begin
                chk_cnt++;
                assert (!out_valid) else begin
                    err_cnt++;
                    $display("ERR %0t: valid high right after redirect", $time);
                end
            end
            hold_chk   = out_valid && !out_ready_i && !redirect_i;
            prev_out   = out;
            redir_seen = redirect_i;
            if (redirect_i) begin
                idx = redir_idx;
            end else if (out_valid && out_ready_i && idx < N_INSTR) begin
                chk_cnt++;
                assert (out.pc == start_pc[idx] && out.instr == exp_instr[idx]
                        && out.is_c == exp_c[idx] && out.illegal == exp_ill[idx]
                        && out.pc_next == start_pc[idx] + (exp_c[idx] ? 32'd2 : 32'd4))
                    else begin
                        err_cnt++;
                        $display("ERR %0t: instr %0d pc %h got %h c%0b il%0b, expected %h %h",
                                 $time, idx, out.pc, out.instr, out.is_c, out.illegal,
                                 start_pc[idx], exp_instr[idx]);
                    end
                idx++;
            end
        end
    end

    initial begin
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        out_ready_i   = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        wb_rsp        = '0;
        void'($urandom(32'h77a7898c));
        build_program();
        wait (idx >= N_INSTR);
        repeat (2) @(negedge clk_i);
        $display("checks %0d, errors %0d, redirects %0d", chk_cnt, err_cnt, redir_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
src/isa_pkg.sv
src/fetch_pkg.sv
src/fetch_ctrl.sv
src/pc_counter.sv
src/parcel_aligner.sv
src/rvc_expander.sv
src/fetch_top.sv
sim/fetch_assertions.sv
sim/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rv32ic_fetch

sources:
  - src/isa_pkg.sv
  - src/fetch_pkg.sv
  - src/fetch_ctrl.sv
  - src/pc_counter.sv
  - src/parcel_aligner.sv
  - src/rvc_expander.sv
  - src/fetch_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/fetch_assertions.sv
      - sim/fetch_tb.sv
